//--- verilog/resonant_config.svh
`ifndef RESONANT_CONFIG_SVH
`define RESONANT_CONFIG_SVH

// ############################################################
// data path widths

`define RES_SAMPLE_W 18 // samples, states, coefficients
`define RES_ACC_W 24 // estimate, holds the sum of all states
`define RES_Q 14 // fraction bits of the coefficients

// ############################################################
// harmonic table

`define RES_MAX_HARM 32
`define RES_HARM_W 5 // index into the table

// ############################################################
// host write port

`define RES_AXI_ADDR_W 9 // byte address
`define RES_AXI_DATA_W 32
`define RES_NHARM_ADDR 9'h100 // active count minus one

`endif

//--- verilog/resonant_types_pkg.sv
`include "resonant_config.svh"

package resonant_types_pkg;

	// ############################################################
	// signal values

	// sample, resonator state or error
	typedef logic signed [`RES_SAMPLE_W-1:0] sample_t;

	// fixed point, RES_Q fraction bits
	typedef logic signed [`RES_SAMPLE_W-1:0] coef_t;

	// sum of the states of one pass
	typedef logic signed [`RES_ACC_W-1:0] acc_t;

	// ############################################################
	// addressing

	typedef logic [`RES_HARM_W-1:0] harm_idx_t; // 0 .. RES_MAX_HARM-1

endpackage

//--- verilog/resonant_ctrl_pkg.sv
`include "resonant_config.svh"

package resonant_ctrl_pkg;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_WALK, // one harmonic issued per cycle
		SEQ_DRAIN // wait for the estimate
	} seq_state_e;

	// one harmonic in the pipeline
	typedef struct packed {
		logic valid;
		logic first;
		logic last;
		resonant_types_pkg::harm_idx_t idx;
	} mac_ctrl_t;

	typedef struct packed {
		resonant_types_pkg::coef_t cos_k;
		resonant_types_pkg::coef_t gain_g;
	} coef_pair_t;

	typedef struct packed {
		resonant_types_pkg::sample_t x1; // last state
		resonant_types_pkg::sample_t x2; // state before that
	} state_pair_t;

	// ############################################################
	// AXI4-Lite write channels

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	typedef struct packed {
		logic awvalid;
		logic [`RES_AXI_ADDR_W-1:0] awaddr;
		logic wvalid;
		logic [`RES_AXI_DATA_W-1:0] wdata;
		logic [`RES_AXI_DATA_W/8-1:0] wstrb;
		logic bready;
	} axil_wr_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
	} axil_wr_rsp_t;

endpackage

//--- verilog/coef_axil_slave.sv
`include "resonant_config.svh"

module coef_axil_slave (
	input  logic clk_i,
	input  logic harmonics_rst,
	input  resonant_ctrl_pkg::axil_wr_req_t req_i,
	output resonant_ctrl_pkg::axil_wr_rsp_t rsp_o,
	input  logic busy_i,
	input  resonant_types_pkg::harm_idx_t rd_idx_i,
	output resonant_ctrl_pkg::coef_pair_t coef_o,
	output resonant_types_pkg::harm_idx_t nharm_o
);

	resonant_ctrl_pkg::coef_pair_t coef_mem [`RES_MAX_HARM];

	logic accept;
	logic wr_en;
	logic bvalid_r;
	logic in_table; // low half of the map
	resonant_types_pkg::harm_idx_t wr_idx;
	resonant_types_pkg::coef_t wr_val;

	// ############################################################
	// handshake

	// address and data taken together, none while a response is pending
	assign accept = req_i.awvalid && req_i.wvalid && !bvalid_r && !busy_i;

	assign rsp_o = '{
		awready: accept,
		wready: accept,
		bvalid: bvalid_r,
		bresp: resonant_ctrl_pkg::AXI_RESP_OKAY
	};

	// ############################################################
	// decode, word 2h is cos_k and word 2h+1 is gain_g

	assign in_table = !req_i.awaddr[`RES_AXI_ADDR_W-1];
	assign wr_idx = req_i.awaddr[`RES_HARM_W+2:3];
	assign wr_val = resonant_types_pkg::coef_t'(req_i.wdata[`RES_SAMPLE_W-1:0]);
	assign wr_en = accept && (req_i.wstrb != '0); // no strobes, no change

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			bvalid_r <= 1'b0;
			nharm_o <= '0; // one harmonic
			for (int h = 0; h < `RES_MAX_HARM; h++)
				coef_mem[h] <= '0;
		end else begin
			if (accept)
				bvalid_r <= 1'b1;
			else if (req_i.bready)
				bvalid_r <= 1'b0;

			if (wr_en) begin
				if (req_i.awaddr == `RES_NHARM_ADDR) begin
					nharm_o <= req_i.wdata[`RES_HARM_W-1:0];
				end else if (in_table) begin
					if (req_i.awaddr[2])
						coef_mem[wr_idx].gain_g <= wr_val;
					else
						coef_mem[wr_idx].cos_k <= wr_val;
				end
			end
		end
	end

	// read port for the walk
	always_ff @(posedge clk_i) begin
		coef_o <= coef_mem[rd_idx_i];
	end

endmodule

//--- verilog/state_store.sv
`include "resonant_config.svh"

module state_store (
	input  logic clk_i,
	input  logic harmonics_rst,
	input  resonant_types_pkg::harm_idx_t rd_idx_i,
	output resonant_ctrl_pkg::state_pair_t state_o,
	input  logic we_i,
	input  resonant_types_pkg::harm_idx_t wr_idx_i,
	input  resonant_ctrl_pkg::state_pair_t state_i
);

	resonant_ctrl_pkg::state_pair_t state_mem [`RES_MAX_HARM];

	// ############################################################
	// write back from the datapath

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			for (int h = 0; h < `RES_MAX_HARM; h++)
				state_mem[h] <= '0; // resonators start at rest
		end else if (we_i) begin
			state_mem[wr_idx_i] <= state_i;
		end
	end

	// ############################################################
	// registered read, same timing as the coefficient table

	always_ff @(posedge clk_i) begin
		state_o <= state_mem[rd_idx_i]; // old value on a same-edge write
	end

endmodule

//--- verilog/harmonic_sequencer.sv
module harmonic_sequencer (
	input  logic clk_i,
	input  logic harmonics_rst,
	input  logic start_i,
	input  resonant_types_pkg::sample_t sample_i,
	input  resonant_types_pkg::harm_idx_t nharm_i,
	input  logic done_i,
	output resonant_ctrl_pkg::mac_ctrl_t ctrl_o,
	output resonant_types_pkg::sample_t sample_o,
	output logic busy_o
);

	resonant_ctrl_pkg::seq_state_e state;
	resonant_types_pkg::harm_idx_t last_idx; // count taken at start
	resonant_types_pkg::harm_idx_t next_idx;
	logic take;

	assign take = (state == resonant_ctrl_pkg::SEQ_IDLE) && start_i;
	assign next_idx = ctrl_o.idx + 1'b1;
	assign busy_o = (state != resonant_ctrl_pkg::SEQ_IDLE);

	// ############################################################
	// pass control

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			state <= resonant_ctrl_pkg::SEQ_IDLE;
			ctrl_o <= '0;
		end else begin
			case (state)
				resonant_ctrl_pkg::SEQ_IDLE: begin
					if (start_i) begin
						state <= resonant_ctrl_pkg::SEQ_WALK;
						ctrl_o.valid <= 1'b1;
						ctrl_o.first <= 1'b1;
						ctrl_o.last <= (nharm_i == '0);
						ctrl_o.idx <= '0;
					end
				end
				resonant_ctrl_pkg::SEQ_WALK: begin
					if (ctrl_o.last) begin
						state <= resonant_ctrl_pkg::SEQ_DRAIN;
						ctrl_o <= '0; // pipeline empties behind us
					end else begin
						ctrl_o.first <= 1'b0;
						ctrl_o.last <= (next_idx == last_idx);
						ctrl_o.idx <= next_idx;
					end
				end
				resonant_ctrl_pkg::SEQ_DRAIN: begin
					if (done_i)
						state <= resonant_ctrl_pkg::SEQ_IDLE;
				end
				default: begin
					state <= resonant_ctrl_pkg::SEQ_IDLE;
					ctrl_o <= '0;
				end
			endcase
		end
	end

	// ############################################################
	// held for the whole pass

	always_ff @(posedge clk_i) begin
		if (take) begin
			sample_o <= sample_i;
			last_idx <= nharm_i; // a write during the pass cannot move the end
		end
	end

endmodule

//--- verilog/resonator_mac.sv
`include "resonant_config.svh"

module resonator_mac (
	input  logic clk_i,
	input  logic harmonics_rst,
	input  resonant_ctrl_pkg::mac_ctrl_t ctrl_i,
	input  resonant_types_pkg::sample_t sample_i,
	input  resonant_ctrl_pkg::coef_pair_t coef_i,
	input  resonant_ctrl_pkg::state_pair_t state_i,
	output logic we_o,
	output resonant_types_pkg::harm_idx_t wr_idx_o,
	output resonant_ctrl_pkg::state_pair_t state_o,
	output logic done_o,
	output resonant_types_pkg::acc_t est_o
);

	localparam int PROD_W = 2 * `RES_SAMPLE_W;

	resonant_ctrl_pkg::mac_ctrl_t ctrl_d; // lines up with memory data
	resonant_ctrl_pkg::mac_ctrl_t ctrl_w; // lines up with the new state
	resonant_types_pkg::sample_t err;
	resonant_types_pkg::sample_t err_r;
	resonant_types_pkg::acc_t sum_r;
	resonant_types_pkg::acc_t sum_next;
	logic signed [PROD_W-1:0] prod_g;
	logic signed [PROD_W-1:0] prod_c;
	logic signed [PROD_W-1:0] new_x1;

	// ############################################################
	// new state

	// one error per pass, against the previous estimate
	assign err = ctrl_d.first ? resonant_types_pkg::sample_t'(sample_i - est_o) : err_r;

	assign prod_g = coef_i.gain_g * err;
	assign prod_c = coef_i.cos_k * state_i.x1;
	assign new_x1 = (prod_g >>> `RES_Q) + (prod_c >>> `RES_Q) - state_i.x2;

	always_ff @(posedge clk_i) begin
		if (ctrl_d.valid) begin
			state_o.x1 <= resonant_types_pkg::sample_t'(new_x1); // wraps
			state_o.x2 <= state_i.x1;
		end
		if (ctrl_d.valid && ctrl_d.first)
			err_r <= err;
		if (ctrl_w.valid)
			sum_r <= sum_next;
	end

	assign we_o = ctrl_w.valid;
	assign wr_idx_o = ctrl_w.idx;

	// ############################################################
	// estimate

	always_comb begin
		sum_next = resonant_types_pkg::acc_t'(state_o.x1);
		if (!ctrl_w.first)
			sum_next = sum_r + resonant_types_pkg::acc_t'(state_o.x1);
	end

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			ctrl_d <= '0;
			ctrl_w <= '0;
			done_o <= 1'b0;
			est_o <= '0;
		end else begin
			ctrl_d <= ctrl_i;
			ctrl_w <= ctrl_d;
			done_o <= ctrl_w.valid && ctrl_w.last;
			if (ctrl_w.valid && ctrl_w.last)
				est_o <= sum_next; // held until the next pass ends
		end
	end

endmodule

//--- verilog/resonant_top.sv
module resonant_top (
	input  logic clk_i,
	input  logic harmonics_rst,
	input  resonant_types_pkg::sample_t sample_i,
	input  logic start_i,
	input  resonant_ctrl_pkg::axil_wr_req_t axil_req_i,
	output resonant_ctrl_pkg::axil_wr_rsp_t axil_rsp_o,
	output logic busy_o,
	output logic done_o,
	output resonant_types_pkg::acc_t est_o
);

	resonant_ctrl_pkg::mac_ctrl_t ctrl;
	resonant_ctrl_pkg::coef_pair_t coef;
	resonant_ctrl_pkg::state_pair_t state_rd;
	resonant_ctrl_pkg::state_pair_t state_wr;
	resonant_types_pkg::sample_t pass_sample;
	resonant_types_pkg::harm_idx_t nharm;
	resonant_types_pkg::harm_idx_t wr_idx;
	logic we;

	harmonic_sequencer u_seq (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst),
		.start_i(start_i), .sample_i(sample_i), .nharm_i(nharm), .done_i(done_o),
		.ctrl_o(ctrl), .sample_o(pass_sample), .busy_o(busy_o)
	);

	coef_axil_slave u_coef (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst),
		.req_i(axil_req_i), .rsp_o(axil_rsp_o), .busy_i(busy_o),
		.rd_idx_i(ctrl.idx), .coef_o(coef), .nharm_o(nharm)
	);

	state_store u_state (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst),
		.rd_idx_i(ctrl.idx), .state_o(state_rd),
		.we_i(we), .wr_idx_i(wr_idx), .state_i(state_wr)
	);

	resonator_mac u_mac (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst),
		.ctrl_i(ctrl), .sample_i(pass_sample), .coef_i(coef), .state_i(state_rd),
		.we_o(we), .wr_idx_o(wr_idx), .state_o(state_wr),
		.done_o(done_o), .est_o(est_o)
	);

endmodule

//--- testbench/resonant_properties.sv
`include "resonant_config.svh"

module resonant_properties (
	input  logic clk_i,
	input  logic harmonics_rst,
	input  resonant_types_pkg::sample_t sample_i,
	input  logic start_i,
	input  resonant_ctrl_pkg::axil_wr_req_t req_i,
	input  resonant_ctrl_pkg::axil_wr_rsp_t rsp_i,
	input  logic busy_i,
	input  logic done_i,
	input  resonant_types_pkg::acc_t est_i,
	input  resonant_types_pkg::harm_idx_t nharm_i
);

	int fail_count = 0;
	int pass_cycle; // edges since the sample was taken
	int pass_len;
	logic take;
	logic wr;
	logic [`RES_AXI_ADDR_W-3:0] word;
	logic gain_seen; // any nonzero gain since reset
	logic single_ok; // only one-harmonic passes since reset
	resonant_types_pkg::coef_t cos0;
	resonant_types_pkg::coef_t gain0;
	resonant_types_pkg::sample_t x1;
	resonant_types_pkg::sample_t x2;
	resonant_types_pkg::sample_t err_model;
	resonant_types_pkg::sample_t x_new;
	resonant_types_pkg::acc_t est_model;

	assign take = start_i && !busy_i;
	assign wr = rsp_i.awready && rsp_i.wready && (req_i.wstrb != '0);
	assign word = req_i.awaddr[`RES_AXI_ADDR_W-1:2];

	// ############################################################
	// shadow of harmonic 0

	function automatic resonant_types_pkg::sample_t resonate(
		input resonant_types_pkg::coef_t c,
		input resonant_types_pkg::coef_t g,
		input resonant_types_pkg::sample_t e,
		input resonant_types_pkg::sample_t s1,
		input resonant_types_pkg::sample_t s2
	);
		longint drive;
		longint feedback;
		drive = (longint'(g) * longint'(e)) >>> `RES_Q;
		feedback = (longint'(c) * longint'(s1)) >>> `RES_Q;
		return resonant_types_pkg::sample_t'(drive + feedback - longint'(s2)); // wraps
	endfunction

	always_comb begin
		err_model = resonant_types_pkg::sample_t'(longint'(sample_i) - longint'(est_model));
		x_new = resonate(cos0, gain0, err_model, x1, x2);
	end

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			pass_cycle <= 0;
			pass_len <= 1;
			gain_seen <= 1'b0;
			single_ok <= 1'b1;
			cos0 <= '0;
			gain0 <= '0;
			x1 <= '0;
			x2 <= '0;
			est_model <= '0;
		end else begin
			if (wr && word < 2 * `RES_MAX_HARM) begin
				if (word[0] && req_i.wdata[`RES_SAMPLE_W-1:0] != '0)
					gain_seen <= 1'b1;
				if (word == 0)
					cos0 <= resonant_types_pkg::coef_t'(req_i.wdata[`RES_SAMPLE_W-1:0]);
				if (word == 1)
					gain0 <= resonant_types_pkg::coef_t'(req_i.wdata[`RES_SAMPLE_W-1:0]);
			end
			if (take) begin
				pass_cycle <= 1;
				pass_len <= int'(nharm_i) + 1;
				if (nharm_i != '0)
					single_ok <= 1'b0; // shadow no longer tracks the sum
				x1 <= x_new;
				x2 <= x1;
				est_model <= resonant_types_pkg::acc_t'(x_new);
			end else if (busy_i) begin
				pass_cycle <= pass_cycle + 1;
			end
		end
	end

	// ############################################################
	// checks

	assert property (@(posedge clk_i) $fell(harmonics_rst)
		|-> !busy_i && !done_i && !rsp_i.bvalid && est_i == '0)
		else begin
			fail_count++;
			$error("Error at %0t: outputs not clear after reset", $time);
		end

	assert property (@(posedge clk_i) disable iff (harmonics_rst)
		rsp_i.awready == rsp_i.wready)
		else begin
			fail_count++;
			$error("Error at %0t: awready and wready not raised together", $time);
		end

	assert property (@(posedge clk_i) disable iff (harmonics_rst) rsp_i.awready
		|=> rsp_i.bvalid && rsp_i.bresp == resonant_ctrl_pkg::AXI_RESP_OKAY)
		else begin
			fail_count++;
			$error("Error at %0t: no OKAY response after awready", $time);
		end

	assert property (@(posedge clk_i) disable iff (harmonics_rst)
		rsp_i.bvalid && !req_i.bready |=> rsp_i.bvalid)
		else begin
			fail_count++;
			$error("Error at %0t: bvalid dropped before bready", $time);
		end

	assert property (@(posedge clk_i) disable iff (harmonics_rst) busy_i |-> !rsp_i.awready)
		else begin
			fail_count++;
			$error("Error at %0t: awready high during a pass", $time);
		end

	assert property (@(posedge clk_i) disable iff (harmonics_rst)
		done_i |-> busy_i && pass_cycle == pass_len + 3)
		else begin
			fail_count++;
			$error("Error at %0t: done_o after %0d edges, expected %0d", $time,
				pass_cycle, pass_len + 3);
		end

	assert property (@(posedge clk_i) disable iff (harmonics_rst) !gain_seen |-> est_i == '0)
		else begin
			fail_count++;
			$error("Error at %0t: est_o %0d with all gains zero", $time, est_i);
		end

	assert property (@(posedge clk_i) disable iff (harmonics_rst)
		done_i && single_ok |-> est_i == est_model)
		else begin
			fail_count++;
			$error("Error at %0t: est_o %0d, expected %0d", $time, est_i, est_model);
		end

endmodule

//--- testbench/tb_resonant.sv
`include "resonant_config.svh"

module tb_resonant;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 5;
	localparam int SAMPLE_COUNT = 40;
	localparam int WRITE_COUNT = 79;
	localparam int WATCHDOG_CYCLES = SAMPLE_COUNT * (`RES_MAX_HARM + 10) + WRITE_COUNT * 10;

	logic clk_i = 1'b0;
	logic harmonics_rst;
	logic start_i;
	logic busy_o;
	logic done_o;
	resonant_types_pkg::sample_t sample_i;
	resonant_types_pkg::acc_t est_o;
	resonant_ctrl_pkg::axil_wr_req_t axil_req;
	resonant_ctrl_pkg::axil_wr_rsp_t axil_rsp;
	int seed = 32'h330e57c8;
	int tb_errors = 0; // handshake timeouts

	resonant_top dut (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst),
		.sample_i(sample_i), .start_i(start_i),
		.axil_req_i(axil_req), .axil_rsp_o(axil_rsp),
		.busy_o(busy_o), .done_o(done_o), .est_o(est_o)
	);

	bind resonant_top resonant_properties props (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst),
		.sample_i(sample_i), .start_i(start_i),
		.req_i(axil_req_i), .rsp_i(axil_rsp_o),
		.busy_i(busy_o), .done_i(done_o), .est_i(est_o), .nharm_i(nharm)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	// ############################################################
	// stimulus tasks

	task automatic apply_reset();
		harmonics_rst = 1'b1;
		repeat (3) @(posedge clk_i);
		#DRIVE_DELAY;
		harmonics_rst = 1'b0;
	endtask

	task automatic axi_write(input logic [`RES_AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		input int lag);
		int waited;
		waited = 0;
		@(posedge clk_i);
		#DRIVE_DELAY;
		axil_req.awvalid = 1'b1;
		axil_req.awaddr = addr;
		axil_req.wvalid = 1'b1;
		axil_req.wdata = data;
		axil_req.wstrb = '1;
		@(negedge clk_i);
		while (!axil_rsp.awready && waited < `RES_MAX_HARM + 10) begin
			@(negedge clk_i);
			waited++;
		end
		if (!axil_rsp.awready) begin
			tb_errors++;
			$display("write to address %h was never accepted", addr);
		end
		@(posedge clk_i);
		#DRIVE_DELAY;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		repeat (lag) begin // response left waiting
			@(posedge clk_i);
			#DRIVE_DELAY;
		end
		axil_req.bready = 1'b1;
		@(posedge clk_i);
		#DRIVE_DELAY;
		axil_req.bready = 1'b0;
	endtask

	task automatic run_sample(input resonant_types_pkg::sample_t value, input logic retrigger);
		int waited;
		waited = 0;
		@(posedge clk_i);
		#DRIVE_DELAY;
		sample_i = value;
		start_i = 1'b1;
		@(posedge clk_i);
		#DRIVE_DELAY;
		if (retrigger) begin
			sample_i = resonant_types_pkg::sample_t'($random(seed)); // must be ignored
			repeat (2) begin
				@(posedge clk_i);
				#DRIVE_DELAY;
			end
		end
		start_i = 1'b0;
		@(negedge clk_i);
		while (!done_o && waited < `RES_MAX_HARM + 10) begin
			@(negedge clk_i);
			waited++;
		end
		if (!done_o) begin
			tb_errors++;
			$display("pass never finished, no done_o after %0d cycles", waited);
		end
	endtask

	// ############################################################
	// test sequence

	initial begin
		start_i = 1'b0;
		sample_i = '0;
		axil_req = '0;
		apply_reset();

		// four harmonics, gains all zero
		axi_write(`RES_NHARM_ADDR, 32'd3, 0);
		for (int h = 0; h < 4; h++) begin
			axi_write(9'(h * 8), $random(seed), h % 3);
			axi_write(9'(h * 8 + 4), 32'd0, 0);
		end
		for (int i = 0; i < 8; i++) begin
			if (i == 3) begin
				fork
					run_sample(resonant_types_pkg::sample_t'($random(seed)), 1'b0);
					begin
						repeat (2) @(posedge clk_i);
						axi_write(9'd16, $random(seed), 1); // lands while busy
					end
				join
			end else begin
				run_sample(resonant_types_pkg::sample_t'($random(seed)), i[0]);
			end
		end

		// one harmonic against the shadow model
		@(posedge clk_i);
		#DRIVE_DELAY;
		apply_reset();
		axi_write(`RES_NHARM_ADDR, 32'd0, 0);
		axi_write(9'd0, $random(seed), 0);
		axi_write(9'd4, $random(seed), 2);
		repeat (24) run_sample(resonant_types_pkg::sample_t'($random(seed)), 1'b0);

		// full table, then eight harmonics
		axi_write(`RES_NHARM_ADDR, `RES_MAX_HARM - 1, 1);
		for (int h = 0; h < `RES_MAX_HARM; h++) begin
			axi_write(9'(h * 8), $random(seed), 0);
			axi_write(9'(h * 8 + 4), $random(seed), h % 2);
		end
		repeat (4) run_sample(resonant_types_pkg::sample_t'($random(seed)), 1'b1);
		axi_write(`RES_NHARM_ADDR, 32'd7, 0);
		repeat (4) run_sample(resonant_types_pkg::sample_t'($random(seed)), 1'b0);

		repeat (4) @(posedge clk_i);
		$display("errors: %0d assertion failures, %0d handshake timeouts",
			dut.props.fail_count, tb_errors);
		if (dut.props.fail_count == 0 && tb_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+verilog
verilog/resonant_types_pkg.sv
verilog/resonant_ctrl_pkg.sv
verilog/coef_axil_slave.sv
verilog/state_store.sv
verilog/harmonic_sequencer.sv
verilog/resonator_mac.sv
verilog/resonant_top.sv
testbench/resonant_properties.sv
testbench/tb_resonant.sv
